//--- calc_key_pkg.sv
`default_nettype none

package calc_key_pkg;

	////////////////////////////////////////////////////////////////////////////
	// keypad codes, 0 to 9 are digits
	////////////////////////////////////////////////////////////////////////////
	localparam logic [3:0] KEY_ADD   = 4'd10;
	localparam logic [3:0] KEY_SUB   = 4'd11;
	localparam logic [3:0] KEY_CLEAR = 4'd12;
	localparam logic [3:0] KEY_MUL   = 4'd13;
	localparam logic [3:0] KEY_EQUAL = 4'd14;
	localparam logic [3:0] KEY_NONE  = 4'd15; // unused key, dropped in decode

	// what a key means to the rest of the core
	typedef enum logic [2:0] {
		kc_digit,
		kc_add,
		kc_sub,
		kc_mul,
		kc_equal,
		kc_clear,
		kc_none
	} key_class_t;

endpackage

`default_nettype wire

//--- calc_pkg.sv
`default_nettype none

package calc_pkg;

	// default operand width, result is twice this
	localparam int DEF_DATA_W = 16;

	////////////////////////////////////////////////////////////////////////////
	// controller states
	////////////////////////////////////////////////////////////////////////////
	typedef enum logic [2:0] {
		st_left,      // typing operand a
		st_right_add, // typing operand b
		st_right_sub,
		st_right_mul,
		st_equal_add, // result held
		st_equal_sub,
		st_equal_mul
	} calc_state_t;

	// operator picked by A, B or D
	typedef enum logic [1:0] {
		op_add,
		op_sub,
		op_mul
	} calc_op_t;

endpackage

`default_nettype wire

//--- key_decode.sv
`timescale 1ns/1ps
`default_nettype none

module key_decode (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [3:0]               key,
	input  logic                     key_valid,
	output logic                     key_strobe,
	output calc_key_pkg::key_class_t key_class,
	output logic [3:0]               digit
);
	import calc_key_pkg::*;

	key_class_t key_class_d;

	// code to class
	always_comb
	begin
		case (key)
			KEY_ADD:   key_class_d = kc_add;
			KEY_SUB:   key_class_d = kc_sub;
			KEY_MUL:   key_class_d = kc_mul;
			KEY_EQUAL: key_class_d = kc_equal;
			KEY_CLEAR: key_class_d = kc_clear;
			KEY_NONE:  key_class_d = kc_none;
			default:   key_class_d = kc_digit; // 0 to 9
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			key_strobe <= 1'b0;
			key_class  <= kc_none;
		end
		else
		begin
			key_strobe <= key_valid && (key != KEY_NONE); // F never strobes
			if (key_valid)
				key_class <= key_class_d;
		end
	end

	// digit value of the last key
	always_ff @(posedge clk)
	begin
		if (key_valid)
			digit <= key;
	end

	a_key_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(key_valid))
		else $error("key_valid unknown");

endmodule

`default_nettype wire

//--- calc_control.sv
`timescale 1ns/1ps
`default_nettype none

module calc_control (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     key_strobe,
	input  calc_key_pkg::key_class_t key_class,
	output logic                     num_enable1,
	output logic                     num_enable2,
	output logic                     ans_enable,
	output logic                     clear_ops,
	output calc_pkg::calc_op_t       op,
	output calc_pkg::calc_state_t    state
);
	import calc_pkg::*;
	import calc_key_pkg::*;

	calc_state_t next_state;
	calc_op_t    next_op;
	logic        in_right;
	logic        in_equal;
	logic        next_equal;

	assign in_right   = state inside {st_right_add, st_right_sub, st_right_mul};
	assign in_equal   = state inside {st_equal_add, st_equal_sub, st_equal_mul};
	assign next_equal = next_state inside {st_equal_add, st_equal_sub, st_equal_mul};

	////////////////////////////////////////////////////////////////////////////
	// unregistered outputs
	////////////////////////////////////////////////////////////////////////////
	assign clear_ops   = key_strobe && (key_class == kc_clear);
	assign num_enable1 = (state == st_left);
	assign num_enable2 = in_right;

	////////////////////////////////////////////////////////////////////////////
	// next state, moves only on a key strobe
	////////////////////////////////////////////////////////////////////////////
	always_comb
	begin
		next_state = state;
		next_op    = op;
		if (key_strobe && key_class == kc_clear)
			next_state = st_left; // from any state
		else if (key_strobe && !in_equal)
		begin
			case (key_class)
				kc_add:
				begin
					next_state = st_right_add;
					next_op    = op_add;
				end
				kc_sub:
				begin
					next_state = st_right_sub;
					next_op    = op_sub;
				end
				kc_mul:
				begin
					next_state = st_right_mul;
					next_op    = op_mul;
				end
				kc_equal:
				begin
					case (state)
						st_right_add: next_state = st_equal_add;
						st_right_sub: next_state = st_equal_sub;
						st_right_mul: next_state = st_equal_mul;
						default:      next_state = state; // E on left entry ignored
					endcase
				end
				default: next_state = state; // digits handled in operand_entry
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state      <= st_left;
			op         <= op_add;
			ans_enable <= 1'b0;
		end
		else
		begin
			state      <= next_state;
			op         <= next_op;
			ans_enable <= next_equal && !in_equal; // one pulse on entry to equal
		end
	end

	a_one_entry: assert property (@(posedge clk) disable iff (!rst_n)
		!(num_enable1 && num_enable2))
		else $error("both entry enables high");

	a_ans_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		ans_enable |=> !ans_enable)
		else $error("ans_enable longer than one cycle");

endmodule

`default_nettype wire

//--- operand_entry.sv
`timescale 1ns/1ps
`default_nettype none

module operand_entry #(
	parameter int DATA_W = calc_pkg::DEF_DATA_W
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     key_strobe,
	input  calc_key_pkg::key_class_t key_class,
	input  logic [3:0]               digit,
	input  logic                     num_enable1,
	input  logic                     num_enable2,
	input  logic                     clear_ops,
	output logic [DATA_W-1:0]        operand_a,
	output logic [DATA_W-1:0]        operand_b
);
	import calc_key_pkg::*;

	logic digit_hit;
	logic first_op;

	// times ten plus digit, wraps at DATA_W
	function automatic logic [DATA_W-1:0] shift_in(input logic [DATA_W-1:0] val,
		input logic [3:0] d);
		return val * DATA_W'(10) + DATA_W'(d);
	endfunction

	assign digit_hit = key_strobe && (key_class == kc_digit);
	// operator leaving left entry, right operand starts fresh
	assign first_op  = key_strobe && num_enable1 &&
		(key_class inside {kc_add, kc_sub, kc_mul});

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			operand_a <= '0;
			operand_b <= '0;
		end
		else if (clear_ops)
		begin
			operand_a <= '0;
			operand_b <= '0;
		end
		else
		begin
			if (digit_hit && num_enable1)
				operand_a <= shift_in(operand_a, digit);
			if (digit_hit && num_enable2)
				operand_b <= shift_in(operand_b, digit);
			else if (first_op)
				operand_b <= '0;
		end
	end

endmodule

`default_nettype wire

//--- calc_alu.sv
`timescale 1ns/1ps
`default_nettype none

module calc_alu #(
	parameter int DATA_W = calc_pkg::DEF_DATA_W,
	parameter int RES_W  = 2 * calc_pkg::DEF_DATA_W
) (
	input  logic [DATA_W-1:0]   operand_a,
	input  logic [DATA_W-1:0]   operand_b,
	input  calc_pkg::calc_op_t  op,
	output logic [RES_W-1:0]    alu_result
);
	import calc_pkg::*;

	logic [RES_W-1:0] a_ext;
	logic [RES_W-1:0] b_ext;

	// unsigned operands
	assign a_ext = {{(RES_W-DATA_W){1'b0}}, operand_a};
	assign b_ext = {{(RES_W-DATA_W){1'b0}}, operand_b};

	always_comb
	begin
		case (op)
			op_add:  alu_result = a_ext + b_ext;
			op_sub:  alu_result = a_ext - b_ext; // two's complement wrap
			op_mul:  alu_result = a_ext * b_ext; // full product fits RES_W
			default: alu_result = '0;
		endcase
	end

	// only A, B and D pick an operator
	always_comb
	begin
		a_op_legal: assert (op !== calc_op_t'(2'b11))
			else $error("illegal operator");
	end

endmodule

`default_nettype wire

//--- calc_display.sv
`timescale 1ns/1ps
`default_nettype none

module calc_display #(
	parameter int DATA_W = calc_pkg::DEF_DATA_W,
	parameter int RES_W  = 2 * calc_pkg::DEF_DATA_W
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  ans_enable,
	input  calc_pkg::calc_state_t state,
	input  logic [DATA_W-1:0]     operand_a,
	input  logic [DATA_W-1:0]     operand_b,
	input  logic [RES_W-1:0]      alu_result,
	output logic [RES_W-1:0]      display,
	output logic                  result_valid
);
	import calc_pkg::*;

	logic [RES_W-1:0] result_q; // held answer

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			result_q     <= '0;
			result_valid <= 1'b0;
		end
		else
		begin
			if (ans_enable)
				result_q <= alu_result;
			result_valid <= ans_enable; // same edge as the load
		end
	end

	always_comb
	begin
		case (state)
			st_left:                                display = RES_W'(operand_a);
			st_right_add, st_right_sub, st_right_mul: display = RES_W'(operand_b);
			default:                                display = result_q;
		endcase
	end

endmodule

`default_nettype wire

//--- calc_top.sv
`timescale 1ns/1ps
`default_nettype none

module calc_top #(
	parameter int  DATA_W = calc_pkg::DEF_DATA_W,
	localparam int RES_W  = 2 * DATA_W
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [3:0]        key,
	input  logic              key_valid,
	output logic [RES_W-1:0]  display,
	output logic              result_valid
);
	import calc_pkg::*;
	import calc_key_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// internal nets
	////////////////////////////////////////////////////////////////////////////
	logic              key_strobe;
	key_class_t        key_class;
	logic [3:0]        digit;
	logic              num_enable1;
	logic              num_enable2;
	logic              ans_enable;
	logic              clear_ops;
	calc_op_t          op;
	calc_state_t       state;
	logic [DATA_W-1:0] operand_a;
	logic [DATA_W-1:0] operand_b;
	logic [RES_W-1:0]  alu_result;

	key_decode u_decode (
		.clk, .rst_n, .key, .key_valid,
		.key_strobe, .key_class, .digit
	);

	calc_control u_control (
		.clk, .rst_n, .key_strobe, .key_class,
		.num_enable1, .num_enable2, .ans_enable, .clear_ops,
		.op, .state
	);

	operand_entry #(.DATA_W(DATA_W)) u_entry (
		.clk, .rst_n, .key_strobe, .key_class, .digit,
		.num_enable1, .num_enable2, .clear_ops,
		.operand_a, .operand_b
	);

	calc_alu #(.DATA_W(DATA_W), .RES_W(RES_W)) u_alu (
		.operand_a, .operand_b, .op, .alu_result
	);

	calc_display #(.DATA_W(DATA_W), .RES_W(RES_W)) u_display (
		.clk, .rst_n, .ans_enable, .state,
		.operand_a, .operand_b, .alu_result,
		.display, .result_valid
	);

endmodule

`default_nettype wire

//--- calc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module calc_tb;
	import calc_key_pkg::*;

	localparam int DATA_W    = 16;
	localparam int RES_W     = 2 * DATA_W;
	localparam int FIELDS    = 6;  // words per line of the cases file
	localparam int MAX_CASES = 32;
	localparam int RES_WAIT  = 3;  // E drive edge to result_valid, sampled on falling edges
	localparam int TIMEOUT   = 50;

	logic             clk = 1'b0;
	logic             rst_n;
	logic [3:0]       key;
	logic             key_valid;
	logic [RES_W-1:0] display;
	logic             result_valid;

	logic [31:0]      case_mem [0:FIELDS*MAX_CASES-1];
	int               due_q[$];   // falling edge on which a display check is due
	logic [RES_W-1:0] exp_q[$];
	int               neg_cnt    = 0;
	int               err_cnt    = 0;
	int               chk_cnt    = 0;
	int               case_cnt   = 0;
	int               pass_cnt   = 0;
	logic             rv_allowed = 1'b0;
	logic             timed_out  = 1'b0;
	logic [RES_W-1:0] mon_exp;

	calc_top #(.DATA_W(DATA_W)) uut (
		.clk, .rst_n, .key, .key_valid, .display, .result_valid
	);

	always #2 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// display monitor, runs on falling edges
	////////////////////////////////////////////////////////////////////////////
	always @(negedge clk)
	begin
		neg_cnt++;
		if (rst_n)
		begin
			stray_rv: assert (!result_valid || rv_allowed)
				else
				begin
					$display("unexpected result_valid pulse at %0t", $time);
					err_cnt++;
				end
		end
		while (due_q.size() > 0 && due_q[0] <= neg_cnt)
		begin
			void'(due_q.pop_front());
			mon_exp = exp_q.pop_front();
			chk_cnt++;
			disp_ok: assert (display == mon_exp)
				else
				begin
					$display("FAILED %0t: display %h, expected %h", $time, display, mon_exp);
					err_cnt++;
				end
		end
	end

	// random idle cycles between keys, 0 to 3
	task automatic idle_gap;
		int gap;
		gap = int'($urandom % 4);
		repeat (gap)
		begin
			@(posedge clk);
			key_valid <= 1'b0;
		end
	endtask

	task automatic press(input logic [3:0] k, input logic [RES_W-1:0] exp_disp);
		@(posedge clk);
		key_valid <= 1'b1;
		key       <= k;
		due_q.push_back(neg_cnt + 3); // sampled next edge, shown one edge after
		exp_q.push_back(exp_disp);
		idle_gap();
	endtask

	// types the decimal digits of typed, at most limit of them
	task automatic type_number(input logic [31:0] typed, input int limit);
		int          digs[$];
		logic [31:0] v;
		logic [31:0] acc;
		v   = typed;
		acc = '0;
		while (v != 0)
		begin
			digs.push_front(int'(v % 10));
			v = v / 10;
		end
		for (int i = 0; i < digs.size() && i < limit; i++)
		begin
			acc = acc * 10 + 32'(digs[i]);
			press(4'(digs[i]), RES_W'(acc[DATA_W-1:0])); // wraps at DATA_W
		end
	endtask

	task automatic run_case(input int ci);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] expv;
		logic [3:0]  op1;
		logic [3:0]  op2;
		logic        clr;
		int          errs_before;
		int          waited;
		logic        seen;
		a    = case_mem[ci*FIELDS];
		op1  = case_mem[ci*FIELDS+1][3:0];
		op2  = case_mem[ci*FIELDS+2][3:0];
		b    = case_mem[ci*FIELDS+3];
		clr  = case_mem[ci*FIELDS+4][0];
		expv = case_mem[ci*FIELDS+5];
		errs_before = err_cnt;

		press(KEY_CLEAR, '0);
		if (clr)
		begin
			type_number(a, 99);
			press(op1, '0);
			type_number(b, 1);
			press(KEY_CLEAR, '0); // back to left entry
		end
		type_number(a, 99);
		press(op1, '0);
		if (op2 != KEY_NONE)
			press(op2, '0); // operator change, right operand still empty
		type_number(b, 99);

		@(posedge clk);
		rv_allowed = 1'b1;
		key_valid <= 1'b1;
		key       <= KEY_EQUAL;
		waited = 0;
		seen   = 1'b0;
		while (!seen && waited < TIMEOUT)
		begin
			@(posedge clk);
			key_valid <= 1'b0;
			@(negedge clk);
			waited++;
			seen = result_valid;
		end
		if (!seen)
		begin
			$display("timeout: result_valid never rose in case %0d", ci);
			timed_out = 1'b1;
		end
		else
		begin
			chk_cnt += 2;
			lat_ok: assert (waited == RES_WAIT)
				else
				begin
					$display("FAILED %0t: result after %0d cycles, expected %0d",
						$time, waited, RES_WAIT);
					err_cnt++;
				end
			res_ok: assert (display == expv)
				else
				begin
					$display("FAILED %0t: result %h, expected %h", $time, display, expv);
					err_cnt++;
				end
		end
		@(posedge clk);
		rv_allowed = 1'b0;

		// held result ignores digits, operators and a second E
		if (!timed_out)
		begin
			press(4'd7, expv);
			press(KEY_MUL, expv);
			press(KEY_EQUAL, expv);
		end
		@(posedge clk);
		key_valid <= 1'b0;
		waited = 0;
		while (due_q.size() != 0 && waited < TIMEOUT)
		begin
			@(negedge clk);
			waited++;
		end
		if (due_q.size() != 0)
		begin
			$display("timeout: display checks still pending in case %0d", ci);
			timed_out = 1'b1;
		end
		// a pulse from the last E would land inside this window
		repeat (RES_WAIT) @(negedge clk);

		case_cnt++;
		if (err_cnt == errs_before && !timed_out)
		begin
			pass_cnt++;
			$display("case %0d: pass, %h", ci, expv);
		end
		else
			$display("case %0d: fail", ci);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////
	initial
	begin
		rst_n     = 1'b0;
		key       = 4'd0;
		key_valid = 1'b0;
		void'($urandom(29));
		for (int i = 0; i < FIELDS*MAX_CASES; i++)
			case_mem[i] = 32'hFFFF_FFFF; // end marker
		$readmemh("calc_cases.txt", case_mem);
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		for (int ci = 0; ci < MAX_CASES && !timed_out; ci++)
		begin
			if (case_mem[ci*FIELDS] == 32'hFFFF_FFFF)
				break;
			run_case(ci);
		end

		$display("cases %0d, passed %0d, checks %0d, errors %0d",
			case_cnt, pass_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0 && !timed_out && case_cnt > 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- calc_cases.txt
// a_typed op_key op2_key b_typed clear expected, all hex, op2 F means no second operator
// a_typed and b_typed are the numbers keyed in decimal, 0 means no digits keyed
0000007B A F 000001C8 0 00000243
000003E8 B F 00000001 0 000003E7
00000005 B F 00000009 0 FFFFFFFC
000000FA D F 0000012C 0 000124F8
0000FFFF D F 0000FFFF 0 FFFE0001
0001E240 A F 00000007 0 0000E247
0001869F D F 000F4240 0 22D6A5C0
00000028 A D 0000000C 0 000001E0
00000007 D B 0000000A 0 FFFFFFFD
0000001F A F 0000000B 1 0000002A
00000000 B F 00000019 0 FFFFFFE7
00000000 A F 00000000 0 00000000
00011170 A F 0000EA60 0 0000FBD0
0000000C D B 00000005 1 00000007

//--- calc.f
calc_key_pkg.sv
calc_pkg.sv
key_decode.sv
calc_control.sv
operand_entry.sv
calc_alu.sv
calc_display.sv
calc_top.sv
calc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the calculator testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f calc.f --top-module calc_tb -o calc_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/calc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Done: no errors" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
